/* verilog/ssb_demap_config.svh */
`ifndef SSB_DEMAP_CONFIG_SVH
`define SSB_DEMAP_CONFIG_SVH

// FFT framing
`define SSB_NFFT          8
`define SSB_FFT_LEN       256
`define SSB_IQ_W          16
`define SSB_EXP_W         8

// Subcarrier windows, natural FFT order
`define SSB_BWP_LEN       240
`define SSB_BWP_START     8
`define SSB_SSS_LEN       127
`define SSB_SSS_START     64
`define SSB_PBCH_LEN      240
`define SSB_PBCH_START    8
`define SSB_SSS_SYM       4
`define SSB_PBCH_SYM      3

// Frame structure
`define SSB_SYM_PER_SF    14
`define SSB_SF_PER_FRAME  20
`define SSB_SFN_MAX       1023

// Downstream flow control
`define SSB_CREDITS       4
`define SSB_COLL_DEPTH    256

`endif

/* verilog/ssb_demap_pkg.sv */
`include "ssb_demap_config.svh"

package ssb_demap_pkg;

    // One complex subcarrier sample
    typedef struct packed {
        logic signed [`SSB_IQ_W-1:0] re;
        logic signed [`SSB_IQ_W-1:0] im;
    } iq_t;

    // Beat as delivered by the FFT
    typedef struct packed {
        iq_t                    iq;
        logic                   last;
        logic [`SSB_EXP_W-1:0]  blk_exp;
    } fft_beat_t;

    // Timing tag attached to every beat
    typedef struct packed {
        logic [$clog2(`SSB_SFN_MAX + 1)-1:0]  sfn;
        logic [$clog2(`SSB_SF_PER_FRAME)-1:0] subframe;
        logic [$clog2(`SSB_SYM_PER_SF)-1:0]   symbol;
        logic [`SSB_EXP_W-1:0]                blk_exp;
    } ssb_tag_t;

    // Tagged beat, used after the timer and on the BWP output
    typedef struct packed {
        iq_t      iq;
        ssb_tag_t tag;
        logic     last;
    } tagged_beat_t;

endpackage

/* verilog/symbol_timer.sv */
`timescale 1ns/1ps
`include "ssb_demap_config.svh"

module symbol_timer (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  logic                       fft_valid,
    input  ssb_demap_pkg::fft_beat_t   fft_beat,
    output logic                       tag_valid,
    output ssb_demap_pkg::tagged_beat_t tag_beat
);

    localparam int SYM_W = $clog2(`SSB_SYM_PER_SF);
    localparam int SF_W  = $clog2(`SSB_SF_PER_FRAME);
    localparam int SFN_W = $clog2(`SSB_SFN_MAX + 1);

    localparam logic [SYM_W-1:0] SYM_LAST = SYM_W'(`SSB_SYM_PER_SF - 1);
    localparam logic [SF_W-1:0]  SF_LAST  = SF_W'(`SSB_SF_PER_FRAME - 1);
    localparam logic [SFN_W-1:0] SFN_LAST = SFN_W'(`SSB_SFN_MAX);

    logic [SYM_W-1:0] sym_cnt;
    logic [SF_W-1:0]  sf_cnt;
    logic [SFN_W-1:0] sfn_cnt;

    // ~~~~~~~~~~~~~~~~~~~~
    // Frame counters
    // ~~~~~~~~~~~~~~~~~~~~
    // Advance after the last beat of each symbol
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sym_cnt <= '0;
            sf_cnt  <= '0;
            sfn_cnt <= '0;
        end else if (fft_valid && fft_beat.last) begin
            if (sym_cnt == SYM_LAST) begin
                sym_cnt <= '0;
                if (sf_cnt == SF_LAST) begin
                    sf_cnt <= '0;
                    if (sfn_cnt == SFN_LAST) begin
                        sfn_cnt <= '0;
                    end else begin
                        sfn_cnt <= sfn_cnt + 1'b1;
                    end
                end else begin
                    sf_cnt <= sf_cnt + 1'b1;
                end
            end else begin
                sym_cnt <= sym_cnt + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= fft_valid;
        end
    end

    // Tag reflects the symbol this beat belongs to, before any advance
    always_ff @(posedge clk_i) begin
        if (fft_valid) begin
            tag_beat.iq           <= fft_beat.iq;
            tag_beat.last         <= fft_beat.last;
            tag_beat.tag.sfn      <= sfn_cnt;
            tag_beat.tag.subframe <= sf_cnt;
            tag_beat.tag.symbol   <= sym_cnt;
            tag_beat.tag.blk_exp  <= fft_beat.blk_exp;
        end
    end

endmodule

/* verilog/bwp_extractor.sv */
`timescale 1ns/1ps
`include "ssb_demap_config.svh"

module bwp_extractor (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic                        tag_valid,
    input  ssb_demap_pkg::tagged_beat_t tag_beat,
    output logic                        bwp_valid,
    output ssb_demap_pkg::tagged_beat_t bwp_beat,
    output logic                        sss_flag,
    output logic                        pbch_flag
);

    localparam int SC_W = `SSB_NFFT;

    localparam logic [SC_W-1:0] SC_LAST    = SC_W'(`SSB_FFT_LEN - 1);
    localparam logic [SC_W-1:0] BWP_FIRST  = SC_W'(`SSB_BWP_START);
    localparam logic [SC_W-1:0] BWP_LAST   = SC_W'(`SSB_BWP_START + `SSB_BWP_LEN - 1);
    localparam logic [SC_W-1:0] SSS_FIRST  = SC_W'(`SSB_SSS_START);
    localparam logic [SC_W-1:0] SSS_LAST   = SC_W'(`SSB_SSS_START + `SSB_SSS_LEN - 1);
    localparam logic [SC_W-1:0] PBCH_FIRST = SC_W'(`SSB_PBCH_START);
    localparam logic [SC_W-1:0] PBCH_LAST  = SC_W'(`SSB_PBCH_START + `SSB_PBCH_LEN - 1);

    logic [SC_W-1:0] sc_cnt;
    logic            in_bwp;
    logic            in_sss;
    logic            in_pbch;
    logic            sss_sym;
    logic            pbch_sym;

    // ~~~~~~~~~~~~~~~~~~~~
    // Window decode
    // ~~~~~~~~~~~~~~~~~~~~
    assign in_bwp  = (sc_cnt >= BWP_FIRST) && (sc_cnt <= BWP_LAST);
    assign in_sss  = (sc_cnt >= SSS_FIRST) && (sc_cnt <= SSS_LAST);
    assign in_pbch = (sc_cnt >= PBCH_FIRST) && (sc_cnt <= PBCH_LAST);

    // SSB lives in subframe 0 only
    assign sss_sym  = (tag_beat.tag.subframe == '0) && (tag_beat.tag.symbol == `SSB_SSS_SYM);
    assign pbch_sym = (tag_beat.tag.subframe == '0) && (tag_beat.tag.symbol == `SSB_PBCH_SYM);

    // Subcarrier index, realigned on the FFT last beat
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sc_cnt <= '0;
        end else if (tag_valid) begin
            if (tag_beat.last || sc_cnt == SC_LAST) begin
                sc_cnt <= '0;
            end else begin
                sc_cnt <= sc_cnt + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Output registers
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            bwp_valid <= 1'b0;
            sss_flag  <= 1'b0;
            pbch_flag <= 1'b0;
        end else begin
            bwp_valid <= tag_valid && in_bwp;
            sss_flag  <= tag_valid && in_sss && sss_sym;
            pbch_flag <= tag_valid && in_pbch && pbch_sym;
        end
    end

    // Sample and tag pass unchanged, last moves to the BWP edge
    always_ff @(posedge clk_i) begin
        if (tag_valid) begin
            bwp_beat.iq   <= tag_beat.iq;
            bwp_beat.tag  <= tag_beat.tag;
            bwp_beat.last <= (sc_cnt == BWP_LAST);
        end
    end

endmodule

/* verilog/ssb_collector.sv */
`timescale 1ns/1ps
`include "ssb_demap_config.svh"

module ssb_collector #(
    parameter int DEPTH = `SSB_COLL_DEPTH
) (
    input  logic               clk_i,
    input  logic               reset_ni,
    input  logic               in_valid,
    input  ssb_demap_pkg::iq_t in_iq,
    input  logic               credit_return,
    output logic               out_valid,
    output ssb_demap_pkg::iq_t out_iq,
    output logic               overflow
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(`SSB_CREDITS + 1);

    ssb_demap_pkg::iq_t mem [DEPTH];

    // Extra MSB tells full from empty
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic [CW-1:0] credit_cnt;
    logic          empty;
    logic          full;
    logic          push;
    logic          send;

    // ~~~~~~~~~~~~~~~~~~~~
    // FIFO status
    // ~~~~~~~~~~~~~~~~~~~~
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign push  = in_valid && !full;

    // One beat per held credit
    assign send = !empty && (credit_cnt != '0);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Sticky until reset
            if (in_valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= in_iq;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Credits and output
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            credit_cnt <= CW'(`SSB_CREDITS);
            out_valid  <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt - CW'(send) + CW'(credit_return);
            out_valid  <= send;
        end
    end

    always_ff @(posedge clk_i) begin
        if (send) begin
            out_iq <= mem[rd_ptr[AW-1:0]];
        end
    end

endmodule

/* verilog/ssb_demap.sv */
`timescale 1ns/1ps

module ssb_demap (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic                        fft_valid,
    input  ssb_demap_pkg::fft_beat_t    fft_beat,
    input  logic                        sss_credit,
    input  logic                        pbch_credit,
    output logic                        bwp_valid,
    output ssb_demap_pkg::tagged_beat_t bwp_beat,
    output logic                        sss_valid,
    output ssb_demap_pkg::iq_t          sss_iq,
    output logic                        pbch_valid,
    output ssb_demap_pkg::iq_t          pbch_iq,
    output logic                        sss_overflow,
    output logic                        pbch_overflow
);

    logic                        tag_valid;
    ssb_demap_pkg::tagged_beat_t tag_beat;
    logic                        sss_flag;
    logic                        pbch_flag;

    // ~~~~~~~~~~~~~~~~~~~~
    // Timing and BWP
    // ~~~~~~~~~~~~~~~~~~~~
    symbol_timer u_symbol_timer (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .fft_valid (fft_valid),
        .fft_beat  (fft_beat),
        .tag_valid (tag_valid),
        .tag_beat  (tag_beat)
    );

    bwp_extractor u_bwp_extractor (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .tag_valid (tag_valid),
        .tag_beat  (tag_beat),
        .bwp_valid (bwp_valid),
        .bwp_beat  (bwp_beat),
        .sss_flag  (sss_flag),
        .pbch_flag (pbch_flag)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // SSB collectors
    // ~~~~~~~~~~~~~~~~~~~~
    ssb_collector u_sss_collector (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .in_valid      (sss_flag),
        .in_iq         (bwp_beat.iq),
        .credit_return (sss_credit),
        .out_valid     (sss_valid),
        .out_iq        (sss_iq),
        .overflow      (sss_overflow)
    );

    ssb_collector u_pbch_collector (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .in_valid      (pbch_flag),
        .in_iq         (bwp_beat.iq),
        .credit_return (pbch_credit),
        .out_valid     (pbch_valid),
        .out_iq        (pbch_iq),
        .overflow      (pbch_overflow)
    );

endmodule

/* bench/ssb_demap_tb.sv */
`timescale 1ns/1ps
`include "ssb_demap_config.svh"

module ssb_demap_tb;

    localparam int BWP_FIRST   = `SSB_BWP_START;
    localparam int BWP_LAST    = `SSB_BWP_START + `SSB_BWP_LEN - 1;
    localparam int SSS_FIRST   = `SSB_SSS_START;
    localparam int SSS_LAST    = `SSB_SSS_START + `SSB_SSS_LEN - 1;
    localparam int PBCH_FIRST  = `SSB_PBCH_START;
    localparam int PBCH_LAST   = `SSB_PBCH_START + `SSB_PBCH_LEN - 1;
    localparam int DRAIN_LIMIT = 20000;

    // Symbol count, block exponent, idle gap, SSS and PBCH credit delay
    typedef struct packed {
        int         n_sym;
        logic [7:0] blk_exp;
        int         idle;
        int         sss_delay;
        int         pbch_delay;
    } row_t;

    // 300 symbols, crossing the frame wrap into SFN 1
    localparam row_t ROWS [5] = '{
        '{3,   8'h03, 0, 0,  0},
        '{2,   8'h1c, 1, 37, 60},
        '{150, 8'h05, 1, 2,  1},
        '{128, 8'hf0, 0, 1,  3},
        '{17,  8'h42, 1, 9,  25}
    };

    logic                        clk_i;
    logic                        reset_ni;
    logic                        fft_valid;
    ssb_demap_pkg::fft_beat_t    fft_beat;
    logic                        sss_credit;
    logic                        pbch_credit;
    logic                        bwp_valid;
    ssb_demap_pkg::tagged_beat_t bwp_beat;
    logic                        sss_valid;
    ssb_demap_pkg::iq_t          sss_iq;
    logic                        pbch_valid;
    ssb_demap_pkg::iq_t          pbch_iq;
    logic                        sss_overflow;
    logic                        pbch_overflow;

    ssb_demap_pkg::tagged_beat_t exp_bwp [$];
    int                          exp_cycle [$];
    ssb_demap_pkg::iq_t          exp_sss [$];
    ssb_demap_pkg::iq_t          exp_pbch [$];
    int                          sss_due [$];
    int                          pbch_due [$];
    ssb_demap_pkg::ssb_tag_t     m_tag;
    logic [31:0]                 rng = 32'h781;
    int                          cycle = 0;
    int                          sss_out = 0;
    int                          pbch_out = 0;
    int                          sss_delay = 0;
    int                          pbch_delay = 0;

    ssb_demap u_ssb_demap (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle <= cycle + 1;

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic check_iq(input string name, input ssb_demap_pkg::iq_t exp,
                            input ssb_demap_pkg::iq_t got);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    // Tag printed as sfn/subframe/symbol/blk_exp
    task automatic check_tag(input ssb_demap_pkg::ssb_tag_t exp,
                             input ssb_demap_pkg::ssb_tag_t got);
        if (got !== exp) begin
            $display("FAIL at %0d ns: bwp_beat.tag expected %0d/%0d/%0d/%h got %0d/%0d/%0d/%h",
                     $time, exp.sfn, exp.subframe, exp.symbol, exp.blk_exp,
                     got.sfn, got.subframe, got.symbol, got.blk_exp);
            stop_run();
        end
    endtask

    task automatic check_bwp(input ssb_demap_pkg::tagged_beat_t exp,
                             input ssb_demap_pkg::tagged_beat_t got);
        check_iq("bwp_beat.iq", exp.iq, got.iq);
        check_tag(exp.tag, got.tag);
        if (got.last !== exp.last) begin
            $display("FAIL at %0d ns: bwp_beat.last expected %b got %b",
                     $time, exp.last, got.last);
            stop_run();
        end
    endtask

    task automatic check_idle();
        if (bwp_valid !== 1'b0 || sss_valid !== 1'b0 || pbch_valid !== 1'b0 ||
            sss_overflow !== 1'b0 || pbch_overflow !== 1'b0) begin
            $display("Outputs were not idle around reset at %0d ns", $time);
            stop_run();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus and model
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic drive_symbol(input logic [7:0] blk_exp, input int idle);
        ssb_demap_pkg::iq_t          iq;
        ssb_demap_pkg::tagged_beat_t beat;
        m_tag.blk_exp = blk_exp;
        for (int sc = 0; sc < `SSB_FFT_LEN; sc++) begin
            rng = xorshift(rng);
            iq  = ssb_demap_pkg::iq_t'(rng);
            @(posedge clk_i);
            #1;
            fft_valid        = 1'b1;
            fft_beat.iq      = iq;
            fft_beat.last    = (sc == `SSB_FFT_LEN - 1);
            fft_beat.blk_exp = blk_exp;
            if (sc >= BWP_FIRST && sc <= BWP_LAST) begin
                beat.iq   = iq;
                beat.tag  = m_tag;
                beat.last = (sc == BWP_LAST);
                exp_bwp.push_back(beat);
                exp_cycle.push_back(cycle + 2);
            end
            if (m_tag.subframe == 0 && m_tag.symbol == `SSB_SSS_SYM &&
                sc >= SSS_FIRST && sc <= SSS_LAST) begin
                exp_sss.push_back(iq);
            end
            if (m_tag.subframe == 0 && m_tag.symbol == `SSB_PBCH_SYM &&
                sc >= PBCH_FIRST && sc <= PBCH_LAST) begin
                exp_pbch.push_back(iq);
            end
            if (idle != 0) begin
                @(posedge clk_i);
                #1;
                fft_valid = 1'b0;
            end
        end
        // Symbol, subframe and SFN wrap
        if (m_tag.symbol == `SSB_SYM_PER_SF - 1) begin
            m_tag.symbol = '0;
            if (m_tag.subframe == `SSB_SF_PER_FRAME - 1) begin
                m_tag.subframe = '0;
                m_tag.sfn = (m_tag.sfn == `SSB_SFN_MAX) ? '0 : m_tag.sfn + 1'b1;
            end else begin
                m_tag.subframe = m_tag.subframe + 1'b1;
            end
        end else begin
            m_tag.symbol = m_tag.symbol + 1'b1;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Output monitor
    // ~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk_i) begin
        if (reset_ni) begin
            if (sss_overflow || pbch_overflow) begin
                $display("A collector overflowed at %0d ns", $time);
                stop_run();
            end
            if (bwp_valid) begin
                if (exp_bwp.size() == 0) begin
                    $display("Unexpected bandwidth-part beat at %0d ns", $time);
                    stop_run();
                end else if (exp_cycle[0] != cycle) begin
                    $display("FAIL at %0d ns: bwp_valid cycle expected %0d got %0d",
                             $time, exp_cycle[0], cycle);
                    stop_run();
                end else begin
                    void'(exp_cycle.pop_front());
                    check_bwp(exp_bwp.pop_front(), bwp_beat);
                end
            end
            if (sss_valid) begin
                if (exp_sss.size() == 0) begin
                    $display("Unexpected SSS sample at %0d ns", $time);
                    stop_run();
                end else begin
                    check_iq("sss_iq", exp_sss.pop_front(), sss_iq);
                end
                sss_out++;
                sss_due.push_back(cycle + sss_delay);
            end
            if (pbch_valid) begin
                if (exp_pbch.size() == 0) begin
                    $display("Unexpected PBCH sample at %0d ns", $time);
                    stop_run();
                end else begin
                    check_iq("pbch_iq", exp_pbch.pop_front(), pbch_iq);
                end
                pbch_out++;
                pbch_due.push_back(cycle + pbch_delay);
            end
            if (sss_out > `SSB_CREDITS || pbch_out > `SSB_CREDITS) begin
                $display("A collector sent more beats than it held credits at %0d ns", $time);
                stop_run();
            end
        end
    end

    // One credit back per received beat, after the row's delay
    always @(posedge clk_i) begin
        #1;
        if (sss_due.size() != 0 && cycle >= sss_due[0]) begin
            void'(sss_due.pop_front());
            sss_credit = 1'b1;
            sss_out--;
        end else begin
            sss_credit = 1'b0;
        end
        if (pbch_due.size() != 0 && cycle >= pbch_due[0]) begin
            void'(pbch_due.pop_front());
            pbch_credit = 1'b1;
            pbch_out--;
        end else begin
            pbch_credit = 1'b0;
        end
    end

    initial begin
        int waited;
        reset_ni    = 1'b0;
        fft_valid   = 1'b0;
        fft_beat    = '0;
        sss_credit  = 1'b0;
        pbch_credit = 1'b0;
        m_tag       = '0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk_i);
            check_idle();
        end
        @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
        @(posedge clk_i);
        @(negedge clk_i);
        check_idle();

        for (int r = 0; r < 5; r++) begin
            sss_delay  = ROWS[r].sss_delay;
            pbch_delay = ROWS[r].pbch_delay;
            for (int s = 0; s < ROWS[r].n_sym; s++) begin
                drive_symbol(ROWS[r].blk_exp, ROWS[r].idle);
            end
        end
        @(posedge clk_i);
        #1;
        fft_valid = 1'b0;

        // Drain the collectors and the credit returns
        waited = 0;
        while ((exp_bwp.size() != 0 || exp_sss.size() != 0 || exp_pbch.size() != 0 ||
                sss_due.size() != 0 || pbch_due.size() != 0) && waited < DRAIN_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_bwp.size() != 0 || exp_sss.size() != 0 || exp_pbch.size() != 0) begin
            if (exp_bwp.size() != 0) begin
                $display("Timeout: %0d bandwidth-part beats never arrived", exp_bwp.size());
            end
            if (exp_sss.size() != 0) begin
                $display("Timeout: %0d SSS samples never arrived", exp_sss.size());
            end
            if (exp_pbch.size() != 0) begin
                $display("Timeout: %0d PBCH samples never arrived", exp_pbch.size());
            end
            stop_run();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* ssb_demap.f */
+incdir+verilog
verilog/ssb_demap_pkg.sv
verilog/symbol_timer.sv
verilog/bwp_extractor.sv
verilog/ssb_collector.sv
verilog/ssb_demap.sv
bench/ssb_demap_tb.sv
